//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_top
FILELIST := vlog.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) design/tlb_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "All checks passed" $(LOG); then \
		echo "simulation gave no result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- design/tlb.sv
`include "tlb_defs.svh"

module tlb
    import tlb_entry_pkg::*;
    import tlb_lookup_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // search port 1
    input  vpn_t       s_vpn_1,
    input  logic       s_odd_1,
    input  asid_t      s_asid_1,
    output logic       s_found_1,
    output tlb_index_t s_index_1,
    output pfn_t       s_pfn_1,
    output cattr_t     s_c_1,
    output logic       s_d_1,
    output logic       s_v_1,

    // search port 2
    input  vpn_t       s_vpn_2,
    input  logic       s_odd_2,
    input  asid_t      s_asid_2,
    output logic       s_found_2,
    output tlb_index_t s_index_2,
    output pfn_t       s_pfn_2,
    output cattr_t     s_c_2,
    output logic       s_d_2,
    output logic       s_v_2,

    // write port
    input  logic       we,
    input  tlb_index_t w_index,
    input  vpn_t       w_vpn,
    input  asid_t      w_asid,
    input  logic       w_g,
    input  pfn_t       w_pfn0,
    input  cattr_t     w_c0,
    input  logic       w_d0,
    input  logic       w_v0,
    input  pfn_t       w_pfn1,
    input  cattr_t     w_c1,
    input  logic       w_d1,
    input  logic       w_v1,

    // read port
    input  tlb_index_t r_index,
    output vpn_t       r_vpn,
    output asid_t      r_asid,
    output logic       r_g,
    output pfn_t       r_pfn0,
    output cattr_t     r_c0,
    output logic       r_d0,
    output logic       r_v0,
    output pfn_t       r_pfn1,
    output cattr_t     r_c1,
    output logic       r_d1,
    output logic       r_v1
);

    vpn_t      ent_vpn   [`TLB_NUM];
    asid_t     ent_asid  [`TLB_NUM];
    logic      ent_g     [`TLB_NUM];
    tlb_page_t ent_page0 [`TLB_NUM];
    tlb_page_t ent_page1 [`TLB_NUM];

    tlb_page_t w_page0, w_page1;
    tlb_page_t r_page0, r_page1;
    tlb_page_t s_page_1, s_page_2;

    assign w_page0 = '{pfn: w_pfn0, c: w_c0, d: w_d0, v: w_v0};
    assign w_page1 = '{pfn: w_pfn1, c: w_c1, d: w_d1, v: w_v1};

    tlb_entry_array u_array (
        .clk       (clk),
        .reset     (reset),
        .we        (we),
        .w_index   (w_index),
        .w_vpn     (w_vpn),
        .w_asid    (w_asid),
        .w_g       (w_g),
        .w_page0   (w_page0),
        .w_page1   (w_page1),
        .ent_vpn   (ent_vpn),
        .ent_asid  (ent_asid),
        .ent_g     (ent_g),
        .ent_page0 (ent_page0),
        .ent_page1 (ent_page1),
        .r_index   (r_index),
        .r_vpn     (r_vpn),
        .r_asid    (r_asid),
        .r_g       (r_g),
        .r_page0   (r_page0),
        .r_page1   (r_page1)
    );

    tlb_search_port u_search_1 (
        .clk       (clk),
        .vpn       (s_vpn_1),
        .odd       (s_odd_1),
        .asid      (s_asid_1),
        .ent_vpn   (ent_vpn),
        .ent_asid  (ent_asid),
        .ent_g     (ent_g),
        .ent_page0 (ent_page0),
        .ent_page1 (ent_page1),
        .found     (s_found_1),
        .index     (s_index_1),
        .page      (s_page_1)
    );

    tlb_search_port u_search_2 (
        .clk       (clk),
        .vpn       (s_vpn_2),
        .odd       (s_odd_2),
        .asid      (s_asid_2),
        .ent_vpn   (ent_vpn),
        .ent_asid  (ent_asid),
        .ent_g     (ent_g),
        .ent_page0 (ent_page0),
        .ent_page1 (ent_page1),
        .found     (s_found_2),
        .index     (s_index_2),
        .page      (s_page_2)
    );

    // split pages back into loose fields
    assign {s_pfn_1, s_c_1, s_d_1, s_v_1} = s_page_1;
    assign {s_pfn_2, s_c_2, s_d_2, s_v_2} = s_page_2;
    assign {r_pfn0, r_c0, r_d0, r_v0}     = r_page0;
    assign {r_pfn1, r_c1, r_d1, r_v1}     = r_page1;

endmodule

//--- design/tlb_defs.svh
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// number of jtlb entries
`define TLB_NUM     16

// virtual side
`define TLB_VPN_W   19 // vpn2 maps an even/odd page pair
`define TLB_ASID_W  8

// physical side, per page
`define TLB_PFN_W   20
`define TLB_C_W     3  // cache attribute

`endif

//--- design/tlb_entry_array.sv
`include "tlb_defs.svh"

module tlb_entry_array
    import tlb_entry_pkg::*;
    import tlb_lookup_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // write port
    input  logic       we,
    input  tlb_index_t w_index,
    input  vpn_t       w_vpn,
    input  asid_t      w_asid,
    input  logic       w_g,
    input  tlb_page_t  w_page0,
    input  tlb_page_t  w_page1,

    // all entries, for the search ports
    output vpn_t       ent_vpn   [`TLB_NUM],
    output asid_t      ent_asid  [`TLB_NUM],
    output logic       ent_g     [`TLB_NUM],
    output tlb_page_t  ent_page0 [`TLB_NUM],
    output tlb_page_t  ent_page1 [`TLB_NUM],

    // read port
    input  tlb_index_t r_index,
    output vpn_t       r_vpn,
    output asid_t      r_asid,
    output logic       r_g,
    output tlb_page_t  r_page0,
    output tlb_page_t  r_page1
);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                ent_vpn[i]   <= '0;
                ent_asid[i]  <= '0;
                ent_g[i]     <= 1'b0;
                ent_page0[i] <= '0;
                ent_page1[i] <= '0;
            end
        end else if (we) begin
            ent_vpn[w_index]   <= w_vpn;
            ent_asid[w_index]  <= w_asid;
            ent_g[w_index]     <= w_g;
            ent_page0[w_index] <= w_page0;
            ent_page1[w_index] <= w_page1;
        end
    end

    // read is combinational off the current contents
    assign r_vpn   = ent_vpn[r_index];
    assign r_asid  = ent_asid[r_index];
    assign r_g     = ent_g[r_index];
    assign r_page0 = ent_page0[r_index];
    assign r_page1 = ent_page1[r_index];

    // an unknown strobe would corrupt an entry silently
    a_we_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(we))
        else $error("tlb_entry_array: we is unknown");

endmodule

//--- design/tlb_entry_pkg.sv
`include "tlb_defs.svh"

package tlb_entry_pkg;

    // tag fields
    typedef logic [`TLB_VPN_W-1:0]  vpn_t;
    typedef logic [`TLB_ASID_W-1:0] asid_t;

    // page descriptor fields
    typedef logic [`TLB_PFN_W-1:0]  pfn_t;
    typedef logic [`TLB_C_W-1:0]    cattr_t;

    // one physical page of the even/odd pair held by an entry
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;  // dirty means writable
        logic   v;  // valid
    } tlb_page_t;

endpackage

//--- design/tlb_lookup_pkg.sv
`include "tlb_defs.svh"

package tlb_lookup_pkg;

    localparam int TLB_IDX_W = $clog2(`TLB_NUM);

    typedef logic [TLB_IDX_W-1:0] tlb_index_t;

    // one hit bit per entry, bit i is entry i
    typedef logic [`TLB_NUM-1:0] tlb_match_t;

endpackage

//--- design/tlb_search_port.sv
`include "tlb_defs.svh"

module tlb_search_port
    import tlb_entry_pkg::*;
    import tlb_lookup_pkg::*;
(
    input  logic       clk, // assertion sampling only

    // lookup request
    input  vpn_t       vpn,
    input  logic       odd,
    input  asid_t      asid,

    // entry contents
    input  vpn_t       ent_vpn   [`TLB_NUM],
    input  asid_t      ent_asid  [`TLB_NUM],
    input  logic       ent_g     [`TLB_NUM],
    input  tlb_page_t  ent_page0 [`TLB_NUM],
    input  tlb_page_t  ent_page1 [`TLB_NUM],

    // lookup result
    output logic       found,
    output tlb_index_t index,
    output tlb_page_t  page
);

    tlb_match_t match;

    // one comparator per entry
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            match[i] = (vpn == ent_vpn[i]) && ((asid == ent_asid[i]) || ent_g[i]);
        end
    end

    assign found = |match;

    // walk down so the lowest matching entry is the last one written
    always_comb begin
        index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                index = tlb_index_t'(i);
            end
        end
    end

    // and-or select of the even/odd page
    // multiple hits merge bitwise as in the and-or mux in hardware
    always_comb begin
        page = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (match[i]) begin
                page = tlb_page_t'(page | (odd ? ent_page1[i] : ent_page0[i]));
            end
        end
    end

    // priority pick must land on a real hit
    a_index_hits: assert property (@(posedge clk) found |-> match[index])
        else $error("tlb_search_port: index %0d is not a matching entry", index);

    // a miss must not leak a stale translation
    a_miss_zero: assert property (@(posedge clk) !found |-> (page == '0))
        else $error("tlb_search_port: page not zero on miss");

endmodule

//--- verif/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 50; // 100 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release lands 5 ns after an edge like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;
    end

endmodule

//--- verif/tb_top.sv
`include "tlb_defs.svh"

module tb_top
    import tlb_entry_pkg::*;
    import tlb_lookup_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic       found;
        tlb_index_t index;
        tlb_page_t  page;
    } search_res_t;

    logic       clk;
    logic       reset;

    // dut inputs
    logic       we, w_g, w_d0, w_v0, w_d1, w_v1;
    logic       s_odd_1, s_odd_2;
    vpn_t       s_vpn_1, s_vpn_2, w_vpn;
    asid_t      s_asid_1, s_asid_2, w_asid;
    tlb_index_t w_index, r_index;
    pfn_t       w_pfn0, w_pfn1;
    cattr_t     w_c0, w_c1;

    // dut outputs
    logic       s_found_1, s_d_1, s_v_1;
    logic       s_found_2, s_d_2, s_v_2;
    logic       r_g, r_d0, r_v0, r_d1, r_v1;
    tlb_index_t s_index_1, s_index_2;
    pfn_t       s_pfn_1, s_pfn_2, r_pfn0, r_pfn1;
    cattr_t     s_c_1, s_c_2, r_c0, r_c1;
    vpn_t       r_vpn;
    asid_t      r_asid;

    // shadow copy of the entries
    vpn_t       m_vpn   [`TLB_NUM];
    asid_t      m_asid  [`TLB_NUM];
    logic       m_g     [`TLB_NUM];
    tlb_page_t  m_page0 [`TLB_NUM];
    tlb_page_t  m_page1 [`TLB_NUM];

    logic [31:0] seed = 32'h8158;
    int          errors = 0;
    int          checks = 0;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    tlb u_dut (.*);

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16); // fold the better high bits down
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = lcg_next();
        return r[7];
    endfunction

    function automatic tlb_page_t rand_page();
        logic [31:0] r;
        r = lcg_next();
        return r[$bits(tlb_page_t)-1:0];
    endfunction

    // small vpn2 pool that overlaps the distinct entries written earlier
    function automatic vpn_t pool_vpn();
        return vpn_t'(32'h100 + 32'd5 * (lcg_next() % 32'd4));
    endfunction

    // expected lookup from the shadow copy
    function automatic search_res_t ref_search(vpn_t vpn, asid_t asid, logic odd);
        search_res_t res;
        res = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (m_vpn[i] == vpn && (m_g[i] || m_asid[i] == asid)) begin
                if (!res.found) begin
                    res.index = tlb_index_t'(i); // first hit from the bottom
                end
                res.found = 1'b1;
                res.page  = res.page | (odd ? m_page1[i] : m_page0[i]);
            end
        end
        return res;
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_page(string pre, string sfx, tlb_page_t exp,
                              pfn_t pfn, cattr_t c, logic d, logic v);
        check_val({pre, "pfn", sfx}, 32'(exp.pfn), 32'(pfn));
        check_val({pre, "c", sfx}, 32'(exp.c), 32'(c));
        check_val({pre, "d", sfx}, 32'(exp.d), 32'(d));
        check_val({pre, "v", sfx}, 32'(exp.v), 32'(v));
    endtask

    task automatic check_search(string sfx, vpn_t vpn, asid_t asid, logic odd,
                                logic found, tlb_index_t index,
                                pfn_t pfn, cattr_t c, logic d, logic v);
        search_res_t exp;
        exp = ref_search(vpn, asid, odd);
        check_val({"s_found", sfx}, 32'(exp.found), 32'(found));
        check_val({"s_index", sfx}, 32'(exp.index), 32'(index));
        check_page("s_", sfx, exp.page, pfn, c, d, v);
    endtask

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic drive_search(vpn_t vpn1, asid_t asid1, logic odd1,
                                vpn_t vpn2, asid_t asid2, logic odd2);
        s_vpn_1  = vpn1;
        s_asid_1 = asid1;
        s_odd_1  = odd1;
        s_vpn_2  = vpn2;
        s_asid_2 = asid2;
        s_odd_2  = odd2;
    endtask

    // one write with random pages and then the read port points at it
    task automatic drive_write(tlb_index_t idx, vpn_t vpn, asid_t asid, logic g);
        we      = 1'b1;
        w_index = idx;
        w_vpn   = vpn;
        w_asid  = asid;
        w_g     = g;
        {w_pfn0, w_c0, w_d0, w_v0} = rand_page();
        {w_pfn1, w_c1, w_d1, w_v1} = rand_page();
        step();
        we      = 1'b0;
        r_index = idx;
    endtask

    // shadow follows the dut at the sampling edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                m_vpn[i]   = '0;
                m_asid[i]  = '0;
                m_g[i]     = 1'b0;
                m_page0[i] = '0;
                m_page1[i] = '0;
            end
        end else if (we) begin
            m_vpn[w_index]   = w_vpn;
            m_asid[w_index]  = w_asid;
            m_g[w_index]     = w_g;
            m_page0[w_index] = {w_pfn0, w_c0, w_d0, w_v0};
            m_page1[w_index] = {w_pfn1, w_c1, w_d1, w_v1};
        end
    end

    // compare 1 ns before the next edge
    always begin
        @(posedge clk);
        #99;
        if (!reset) begin
            check_search("_1", s_vpn_1, s_asid_1, s_odd_1, s_found_1, s_index_1,
                         s_pfn_1, s_c_1, s_d_1, s_v_1);
            check_search("_2", s_vpn_2, s_asid_2, s_odd_2, s_found_2, s_index_2,
                         s_pfn_2, s_c_2, s_d_2, s_v_2);
            check_val("r_vpn", 32'(m_vpn[r_index]), 32'(r_vpn));
            check_val("r_asid", 32'(m_asid[r_index]), 32'(r_asid));
            check_val("r_g", 32'(m_g[r_index]), 32'(r_g));
            check_page("r_", "0", m_page0[r_index], r_pfn0, r_c0, r_d0, r_v0);
            check_page("r_", "1", m_page1[r_index], r_pfn1, r_c1, r_d1, r_v1);
        end
    end

    initial begin
        int    cycles;
        asid_t asids [`TLB_NUM];

        we = 1'b0;
        w_index = '0;
        w_vpn = '0;
        w_asid = '0;
        w_g = 1'b0;
        {w_pfn0, w_c0, w_d0, w_v0} = '0;
        {w_pfn1, w_c1, w_d1, w_v1} = '0;
        r_index = '0;
        drive_search('0, '0, 1'b0, '0, '0, 1'b0);

        cycles = 0;
        while (reset !== 1'b0 && cycles < 40) begin
            @(posedge clk);
            cycles++;
        end

        if (reset !== 1'b0) begin
            $display("reset still asserted after %0d cycles", cycles);
            $display("Checks failed");
        end else begin
            #5;
            // vpn 0 with asid 0 hits entry 0 of the cleared array
            for (int i = 0; i < `TLB_NUM; i++) begin
                r_index = tlb_index_t'(i);
                step();
            end

            for (int i = 0; i < 4; i++) begin
                drive_write(tlb_index_t'(lcg_next()), vpn_t'(lcg_next()),
                            asid_t'(lcg_next()), 1'b0);
            end

            // distinct vpn2 and own asid per entry
            for (int i = 0; i < `TLB_NUM; i++) begin
                asids[i] = asid_t'(lcg_next());
                drive_write(tlb_index_t'(i), vpn_t'(32'h100 + i), asids[i], 1'b0);
            end
            for (int i = 0; i < `TLB_NUM; i++) begin
                drive_search(vpn_t'(32'h100 + i), asids[i], i[0],
                             vpn_t'(32'h100 + i), asid_t'(asids[i] + 8'd1), !i[0]);
                step();
                drive_search(vpn_t'(32'h100 + i), asid_t'(asids[i] + 8'd1), !i[0],
                             vpn_t'(32'h100 + i), asids[i], i[0]);
                step();
            end

            // any asid hits a global entry
            drive_write(tlb_index_t'(5), vpn_t'(19'h2aaaa), asid_t'(8'h33), 1'b1);
            for (int i = 0; i < 4; i++) begin
                drive_search(vpn_t'(19'h2aaaa), asid_t'(lcg_next()), i[0],
                             vpn_t'(19'h2aaaa), asid_t'(lcg_next()), !i[0]);
                step();
            end

            // on a duplicate tag the lower index wins and pages merge
            drive_write(tlb_index_t'(9), vpn_t'(19'h5a5a5), asid_t'(8'h77), 1'b0);
            drive_write(tlb_index_t'(3), vpn_t'(19'h5a5a5), asid_t'(8'h77), 1'b0);
            for (int i = 0; i < 2; i++) begin
                drive_search(vpn_t'(19'h5a5a5), asid_t'(8'h77), i[0],
                             vpn_t'(19'h5a5a5), asid_t'(8'h77), !i[0]);
                step();
            end

            for (int n = 0; n < 200; n++) begin
                we      = rand_bit();
                w_index = tlb_index_t'(lcg_next());
                w_vpn   = pool_vpn();
                w_asid  = asid_t'(lcg_next() % 32'd3);
                w_g     = rand_bit() && rand_bit() && rand_bit();
                {w_pfn0, w_c0, w_d0, w_v0} = rand_page();
                {w_pfn1, w_c1, w_d1, w_v1} = rand_page();
                drive_search(pool_vpn(), asid_t'(lcg_next() % 32'd3), rand_bit(),
                             pool_vpn(), asid_t'(lcg_next() % 32'd3), rand_bit());
                r_index = tlb_index_t'(lcg_next());
                step();
            end
            we = 1'b0;
            step();

            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/tlb_entry_pkg.sv
design/tlb_lookup_pkg.sv
design/tlb_entry_array.sv
design/tlb_search_port.sv
design/tlb.sv
verif/tb_clock.sv
verif/tb_top.sv
